/* noc_pkg.sv */
// Shared definitions for the 2x2 mesh NoC
// Tile id, payload and flit types, router port indices

`default_nettype none

package noc_pkg;

   // Number of tiles on the 2x2 mesh
   localparam int NUM_TILES = 4;

   // Ports per router, one local and one per mesh dimension
   localparam int NUM_PORTS = 3;

   // Tile number
   // Bit 0 is the X coordinate, bit 1 is the Y coordinate
   typedef logic [1:0] tile_id_t;

   // Message data carried in one flit
   typedef logic [27:0] payload_t;

   // Single-flit packet, destination in the top bits
   typedef struct packed {
      tile_id_t dst;
      tile_id_t src;
      payload_t payload;
   } flit_t;

   // Router port index
   // Local port faces the endpoint, the others face the mesh neighbors
   typedef enum logic [1:0] {
      PORT_LOCAL = 2'd0,
      PORT_X     = 2'd1,
      PORT_Y     = 2'd2
   } port_e;

endpackage

`default_nettype wire

/* noc_fifo.sv */
// Synchronous flit FIFO with valid/ready on both sides
// Circular buffer with read and write pointers and a fill count

`timescale 1ns/1ps
`default_nettype none

module noc_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire                   clk_i,
   input  wire                   arst_n_i,
   input  wire                   in_valid_i,
   input  wire  noc_pkg::flit_t  in_flit_i,
   output logic                  in_ready_o,
   output logic                  out_valid_o,
   output noc_pkg::flit_t        out_flit_o,
   input  wire                   out_ready_i
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   noc_pkg::flit_t   mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_d;
   logic             push;
   logic             pop;

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   // Head entry is visible one cycle after its push
   assign out_valid_o = (count != '0);
   assign out_flit_o  = mem[rd_ptr];

   always_comb begin
      case ({push, pop})
         2'b10:   count_d = count + 1'b1;
         2'b01:   count_d = count - 1'b1;
         default: count_d = count;
      endcase
   end

   // Flit storage is written on each push
   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= in_flit_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         // Ready rises on the first edge after reset release
         in_ready_o <= 1'b0;
      end else begin
         // Pointers wrap at the depth, which need not be a power of two
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count      <= count_d;
         in_ready_o <= (count_d != CNT_W'(FIFO_DEPTH));
      end
   end

endmodule

`default_nettype wire

/* noc_router.sv */
// Three-port mesh router for the 2x2 NoC
// Input FIFO per port, XY route computation, round-robin arbiter per output

`timescale 1ns/1ps
`default_nettype none

module noc_router #(
   parameter noc_pkg::tile_id_t TILE_ID    = '0,
   parameter int                FIFO_DEPTH = 4
) (
   input  wire                        clk_i,
   input  wire                        arst_n_i,
   input  wire  [2:0]                 in_valid_i,
   input  wire  noc_pkg::flit_t [2:0] in_flit_i,
   output logic [2:0]                 in_ready_o,
   output logic [2:0]                 out_valid_o,
   output noc_pkg::flit_t [2:0]       out_flit_o,
   input  wire  [2:0]                 out_ready_i
);

   // FIFO heads, one per input port
   logic [2:0]                head_valid;
   noc_pkg::flit_t [2:0]      head_flit;
   logic [2:0]                head_pop;

   // Output port wanted by each head
   noc_pkg::port_e [2:0]      route;

   // Requests seen by each output, indexed by input
   logic [2:0]                req [noc_pkg::NUM_PORTS];

   // Granted input and priority pointer per output
   logic [1:0]                gnt_idx [noc_pkg::NUM_PORTS];
   logic [1:0]                prio_q  [noc_pkg::NUM_PORTS];

   // Picks the first requester at or after the priority pointer
   function automatic logic [1:0] rr_pick(input logic [2:0] req_v, input logic [1:0] prio);
      logic [1:0] pick;
      int         idx;
      pick = prio;
      // Walk backwards so the nearest requester is the last one written
      for (int k = noc_pkg::NUM_PORTS - 1; k >= 0; k--) begin
         idx = (int'(prio) + k) % noc_pkg::NUM_PORTS;
         if (req_v[idx]) begin
            pick = 2'(idx);
         end
      end
      return pick;
   endfunction

   for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_in
      noc_fifo #(
         .FIFO_DEPTH (FIFO_DEPTH)
      ) u_fifo (
         .clk_i       (clk_i),
         .arst_n_i    (arst_n_i),
         .in_valid_i  (in_valid_i[p]),
         .in_flit_i   (in_flit_i[p]),
         .in_ready_o  (in_ready_o[p]),
         .out_valid_o (head_valid[p]),
         .out_flit_o  (head_flit[p]),
         .out_ready_i (head_pop[p])
      );

      // XY order, correct the X coordinate first and then Y
      always_comb begin
         if (head_flit[p].dst[0] != TILE_ID[0]) begin
            route[p] = noc_pkg::PORT_X;
         end else if (head_flit[p].dst[1] != TILE_ID[1]) begin
            route[p] = noc_pkg::PORT_Y;
         end else begin
            route[p] = noc_pkg::PORT_LOCAL;
         end
      end
   end

   always_comb begin
      head_pop = '0;
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
         for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
            req[o][i] = head_valid[i] && (route[i] == noc_pkg::port_e'(o));
         end
         gnt_idx[o]     = rr_pick(req[o], prio_q[o]);
         out_valid_o[o] = |req[o];
         out_flit_o[o]  = head_flit[gnt_idx[o]];
         // A head leaves only when its output takes the flit
         if (out_valid_o[o] && out_ready_i[o]) begin
            head_pop[gnt_idx[o]] = 1'b1;
         end
      end
   end

   // While stalled the pointer parks on the granted input, so the offered
   // flit stays stable until the transfer
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
            prio_q[o] <= '0;
         end
      end else begin
         for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
            if (out_valid_o[o]) begin
               if (!out_ready_i[o]) begin
                  prio_q[o] <= gnt_idx[o];
               end else if (gnt_idx[o] == 2'(noc_pkg::NUM_PORTS - 1)) begin
                  prio_q[o] <= '0;
               end else begin
                  prio_q[o] <= gnt_idx[o] + 1'b1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* noc_endpoint.sv */
// Tile-side network adapter for the 2x2 NoC
// Builds flits from send requests, buffers inject and eject traffic

`timescale 1ns/1ps
`default_nettype none

module noc_endpoint #(
   parameter noc_pkg::tile_id_t TILE_ID    = '0,
   parameter int                FIFO_DEPTH = 4
) (
   input  wire                       clk_i,
   input  wire                       arst_n_i,

   // Send requests from the tile
   input  wire                       tx_valid_i,
   input  wire  noc_pkg::tile_id_t   tx_dst_i,
   input  wire  noc_pkg::payload_t   tx_payload_i,
   output logic                      tx_ready_o,

   // Delivered messages toward the tile
   output logic                      rx_valid_o,
   output noc_pkg::tile_id_t         rx_src_o,
   output noc_pkg::payload_t         rx_payload_o,
   input  wire                       rx_ready_i,

   // Inject channel into the router local input
   output logic                      inj_valid_o,
   output noc_pkg::flit_t            inj_flit_o,
   input  wire                       inj_ready_i,

   // Eject channel from the router local output
   input  wire                       ej_valid_i,
   input  wire  noc_pkg::flit_t      ej_flit_i,
   output logic                      ej_ready_o
);

   noc_pkg::flit_t tx_flit;
   noc_pkg::flit_t rx_flit;

   // Source is always this tile, the tile only names the destination
   always_comb begin
      tx_flit.dst     = tx_dst_i;
      tx_flit.src     = TILE_ID;
      tx_flit.payload = tx_payload_i;
   end

   // Inject buffer
   // Accepted request shows up on the inject channel one cycle later
   noc_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_inj_fifo (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (tx_valid_i),
      .in_flit_i   (tx_flit),
      .in_ready_o  (tx_ready_o),
      .out_valid_o (inj_valid_o),
      .out_flit_o  (inj_flit_o),
      .out_ready_i (inj_ready_i)
   );

   // Eject buffer
   // A stalled tile fills it and back-pressure reaches the router
   noc_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_ej_fifo (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (ej_valid_i),
      .in_flit_i   (ej_flit_i),
      .in_ready_o  (ej_ready_o),
      .out_valid_o (rx_valid_o),
      .out_flit_o  (rx_flit),
      .out_ready_i (rx_ready_i)
   );

   // Destination field is this tile by construction and is dropped here
   assign rx_src_o     = rx_flit.src;
   assign rx_payload_o = rx_flit.payload;

endmodule

`default_nettype wire

/* system_2x2_noc.sv */
// Top level of the 2x2 tiled message-passing system
// Four endpoints, four routers and the mesh links between them

`timescale 1ns/1ps
`default_nettype none

module system_2x2_noc #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire                                             clk_i,
   input  wire                                             arst_n_i,

   // Send side, one lane per tile
   input  wire  [noc_pkg::NUM_TILES-1:0]                   tx_valid_i,
   input  wire  noc_pkg::tile_id_t [noc_pkg::NUM_TILES-1:0] tx_dst_i,
   input  wire  noc_pkg::payload_t [noc_pkg::NUM_TILES-1:0] tx_payload_i,
   output logic [noc_pkg::NUM_TILES-1:0]                   tx_ready_o,

   // Receive side, one lane per tile
   output logic [noc_pkg::NUM_TILES-1:0]                   rx_valid_o,
   output noc_pkg::tile_id_t [noc_pkg::NUM_TILES-1:0]      rx_src_o,
   output noc_pkg::payload_t [noc_pkg::NUM_TILES-1:0]      rx_payload_o,
   input  wire  [noc_pkg::NUM_TILES-1:0]                   rx_ready_i
);

   // Endpoint side of the local port
   logic                 inj_valid [noc_pkg::NUM_TILES];
   noc_pkg::flit_t       inj_flit  [noc_pkg::NUM_TILES];
   logic                 ej_ready  [noc_pkg::NUM_TILES];

   // Router ports, indexed by port_e
   logic [2:0]           rt_in_ready  [noc_pkg::NUM_TILES];
   logic [2:0]           rt_out_valid [noc_pkg::NUM_TILES];
   noc_pkg::flit_t [2:0] rt_out_flit  [noc_pkg::NUM_TILES];

   for (genvar t = 0; t < noc_pkg::NUM_TILES; t++) begin : g_tile
      // Mesh neighbors differ in one coordinate bit
      localparam int XN = t ^ 1;
      localparam int YN = t ^ 2;

      noc_endpoint #(
         .TILE_ID    (noc_pkg::tile_id_t'(t)),
         .FIFO_DEPTH (FIFO_DEPTH)
      ) u_endpoint (
         .clk_i        (clk_i),
         .arst_n_i     (arst_n_i),
         .tx_valid_i   (tx_valid_i[t]),
         .tx_dst_i     (tx_dst_i[t]),
         .tx_payload_i (tx_payload_i[t]),
         .tx_ready_o   (tx_ready_o[t]),
         .rx_valid_o   (rx_valid_o[t]),
         .rx_src_o     (rx_src_o[t]),
         .rx_payload_o (rx_payload_o[t]),
         .rx_ready_i   (rx_ready_i[t]),
         .inj_valid_o  (inj_valid[t]),
         .inj_flit_o   (inj_flit[t]),
         .inj_ready_i  (rt_in_ready[t][noc_pkg::PORT_LOCAL]),
         .ej_valid_i   (rt_out_valid[t][noc_pkg::PORT_LOCAL]),
         .ej_flit_i    (rt_out_flit[t][noc_pkg::PORT_LOCAL]),
         .ej_ready_o   (ej_ready[t])
      );

      // Inputs are ordered Y, X, local to match the port_e encoding
      noc_router #(
         .TILE_ID    (noc_pkg::tile_id_t'(t)),
         .FIFO_DEPTH (FIFO_DEPTH)
      ) u_router (
         .clk_i       (clk_i),
         .arst_n_i    (arst_n_i),
         .in_valid_i  ({rt_out_valid[YN][noc_pkg::PORT_Y],
                        rt_out_valid[XN][noc_pkg::PORT_X],
                        inj_valid[t]}),
         .in_flit_i   ({rt_out_flit[YN][noc_pkg::PORT_Y],
                        rt_out_flit[XN][noc_pkg::PORT_X],
                        inj_flit[t]}),
         .in_ready_o  (rt_in_ready[t]),
         .out_valid_o (rt_out_valid[t]),
         .out_flit_o  (rt_out_flit[t]),
         // Each output is held off by the neighbor input it feeds
         .out_ready_i ({rt_in_ready[YN][noc_pkg::PORT_Y],
                        rt_in_ready[XN][noc_pkg::PORT_X],
                        ej_ready[t]})
      );
   end

endmodule

`default_nettype wire

/* tb_noc_model.svh */
// Testbench model for the 2x2 NoC
// LCG stimulus source, expected-message queues and typed compare tasks

`ifndef TB_NOC_MODEL_SVH
`define TB_NOC_MODEL_SVH

localparam int NUM_PAIRS = noc_pkg::NUM_TILES * noc_pkg::NUM_TILES;

// Generator state, fixed seed
logic [31:0] lcg_state = 32'h3f1d2102;

// Expected payloads per pair, indexed by src * NUM_TILES + dst
noc_pkg::payload_t exp_q [NUM_PAIRS][$];

int sent_count  = 0;
int recv_count  = 0;
int check_total = 0;
int error_count = 0;

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Upper LCG bits have the longest period
function automatic noc_pkg::tile_id_t rand_tile();
   logic [31:0] r;
   r = lcg_next();
   return r[31:30];
endfunction

function automatic noc_pkg::payload_t rand_payload();
   logic [31:0] r;
   r = lcg_next();
   return r[31:4];
endfunction

task automatic check_src(input noc_pkg::tile_id_t got, exp, input string what);
   check_total++;
   if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s: got %0d, expected %0d", $time, what, got, exp);
   end
endtask

task automatic check_payload(input noc_pkg::payload_t got, exp, input string what);
   check_total++;
   if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s: got %07h, expected %07h", $time, what, got, exp);
   end
endtask

// Per-tile valid and ready vectors
task automatic check_bits(input logic [noc_pkg::NUM_TILES-1:0] got, exp, input string what);
   check_total++;
   if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s: got %b, expected %b", $time, what, got, exp);
   end
endtask

task automatic check_count(input int got, exp, input string what);
   check_total++;
   if (got != exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s: got %0d, expected %0d", $time, what, got, exp);
   end
endtask

// Send seen on a tx port
task automatic expect_msg(input noc_pkg::tile_id_t src, dst, input noc_pkg::payload_t payload);
   exp_q[int'(src) * noc_pkg::NUM_TILES + int'(dst)].push_back(payload);
   sent_count++;
endtask

// Delivery seen on an rx port, oldest message of the pair must match
task automatic receive_msg(input noc_pkg::tile_id_t dst, src, input noc_pkg::payload_t payload);
   int                key;
   noc_pkg::payload_t exp_pay;
   key = int'(src) * noc_pkg::NUM_TILES + int'(dst);
   recv_count++;
   if (exp_q[key].size() == 0) begin
      error_count++;
      $display("At %0t tile %0d received a message from tile %0d that was never sent",
               $time, dst, src);
   end else begin
      exp_pay = exp_q[key].pop_front();
      check_payload(payload, exp_pay, $sformatf("payload from %0d to %0d", src, dst));
   end
endtask

`endif

/* tb_system_2x2_noc.sv */
// Testbench for the 2x2 NoC system
// Clock, reset, traffic phases checked against the model, watchdog and summary

`timescale 1ns/1ps
`default_nettype none

module tb_system_2x2_noc;

   localparam int FIFO_DEPTH     = 4;
   // Rough length of all tests in cycles
   localparam int TEST_CYCLES    = 400;
   localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;

   logic                                       clk_i = 1'b0;
   logic                                       arst_n_i;
   logic [noc_pkg::NUM_TILES-1:0]              tx_valid;
   noc_pkg::tile_id_t [noc_pkg::NUM_TILES-1:0] tx_dst;
   noc_pkg::payload_t [noc_pkg::NUM_TILES-1:0] tx_payload;
   logic [noc_pkg::NUM_TILES-1:0]              tx_ready;
   logic [noc_pkg::NUM_TILES-1:0]              rx_valid;
   noc_pkg::tile_id_t [noc_pkg::NUM_TILES-1:0] rx_src;
   noc_pkg::payload_t [noc_pkg::NUM_TILES-1:0] rx_payload;
   logic [noc_pkg::NUM_TILES-1:0]              rx_ready;

   // Handshakes are sampled on the falling edge before the transferring edge
   logic [noc_pkg::NUM_TILES-1:0]              tx_fire;
   noc_pkg::tile_id_t                          last_rx_src;
   int                                         cycle_count = 0;
   int                                         errs_before;

   // Pending sends per tile with the head on the tx port
   noc_pkg::tile_id_t msg_dst [noc_pkg::NUM_TILES][$];
   noc_pkg::payload_t msg_pay [noc_pkg::NUM_TILES][$];

   `include "tb_noc_model.svh"

   system_2x2_noc #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) uut (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .tx_valid_i   (tx_valid),
      .tx_dst_i     (tx_dst),
      .tx_payload_i (tx_payload),
      .tx_ready_o   (tx_ready),
      .rx_valid_o   (rx_valid),
      .rx_src_o     (rx_src),
      .rx_payload_o (rx_payload),
      .rx_ready_i   (rx_ready)
   );

   // 20 ns clock
   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
   end

   // Monitor feeds the model from both sides of every tile
   always @(negedge clk_i) begin
      if (arst_n_i) begin
         for (int t = 0; t < noc_pkg::NUM_TILES; t++) begin
            tx_fire[t] = tx_valid[t] & tx_ready[t];
            if (tx_fire[t]) begin
               expect_msg(noc_pkg::tile_id_t'(t), tx_dst[t], tx_payload[t]);
            end
            if (rx_valid[t] && rx_ready[t]) begin
               last_rx_src = rx_src[t];
               receive_msg(noc_pkg::tile_id_t'(t), rx_src[t], rx_payload[t]);
            end
         end
      end
   end

   initial begin
      wait (cycle_count >= TIMEOUT_CYCLES);
      $display("Timeout after %0d cycles, messages are still undelivered", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
   end

   // Offers pending sends until all are taken and every sent message is delivered
   task automatic drive_lists(input bit random_rx);
      bit          busy;
      logic [31:0] r;
      busy = 1'b1;
      while (busy) begin
         @(posedge clk_i);
         #2;
         busy = (recv_count < sent_count);
         for (int t = 0; t < noc_pkg::NUM_TILES; t++) begin
            // Head was taken at the edge just passed
            if (tx_fire[t]) begin
               void'(msg_dst[t].pop_front());
               void'(msg_pay[t].pop_front());
            end
            tx_valid[t] = (msg_dst[t].size() != 0);
            if (tx_valid[t]) begin
               tx_dst[t]     = msg_dst[t][0];
               tx_payload[t] = msg_pay[t][0];
               busy          = 1'b1;
            end
            r           = lcg_next();
            rx_ready[t] = random_rx ? r[31] : 1'b1;
         end
      end
      rx_ready = '1;
   endtask

   task automatic fill_random(input int per_tile);
      for (int t = 0; t < noc_pkg::NUM_TILES; t++) begin
         repeat (per_tile) begin
            msg_dst[t].push_back(rand_tile());
            msg_pay[t].push_back(rand_payload());
         end
      end
   endtask

   task automatic report_test(input int num, input string name);
      if (error_count == errs_before) begin
         $display("Test %0d, %s: passed", num, name);
      end else begin
         $display("Test %0d, %s: %0d errors", num, name, error_count - errs_before);
      end
      errs_before = error_count;
   endtask

   initial begin
      noc_pkg::tile_id_t target;
      arst_n_i    = 1'b0;
      tx_valid    = '0;
      tx_dst      = '0;
      tx_payload  = '0;
      rx_ready    = '1;
      tx_fire     = '0;
      last_rx_src = '0;
      errs_before = 0;
      repeat (2) @(posedge clk_i);
      #2;
      arst_n_i = 1'b1;

      // Ready rises on the first edge after release
      @(posedge clk_i);
      repeat (20) begin
         @(negedge clk_i);
         check_bits(rx_valid, '0, "rx_valid with no traffic");
         check_bits(tx_ready, '1, "tx_ready when idle");
      end
      report_test(1, "idle after reset");

      // Sent one at a time so the source of each delivery is known
      for (int s = 0; s < noc_pkg::NUM_TILES; s++) begin
         for (int d = 0; d < noc_pkg::NUM_TILES; d++) begin
            msg_dst[s].push_back(noc_pkg::tile_id_t'(d));
            msg_pay[s].push_back(rand_payload());
            drive_lists(1'b0);
            check_src(last_rx_src, noc_pkg::tile_id_t'(s),
                      $sformatf("source of message %0d to %0d", s, d));
         end
      end
      report_test(2, "every source and destination pair");

      fill_random(50);
      drive_lists(1'b0);
      report_test(3, "random traffic, receivers always ready");

      fill_random(50);
      drive_lists(1'b1);
      report_test(4, "random traffic, receivers stalling");

      // Every tile sends to the target tile including the target itself
      target = rand_tile();
      for (int t = 0; t < noc_pkg::NUM_TILES; t++) begin
         repeat (12) begin
            msg_dst[t].push_back(target);
            msg_pay[t].push_back(rand_payload());
         end
      end
      drive_lists(1'b0);
      report_test(5, "all tiles to one tile");

      for (int k = 0; k < NUM_PAIRS; k++) begin
         if (exp_q[k].size() != 0) begin
            error_count++;
            $display("%0d messages from tile %0d to tile %0d were never delivered",
                     exp_q[k].size(), k / noc_pkg::NUM_TILES, k % noc_pkg::NUM_TILES);
         end
      end
      check_count(recv_count, sent_count, "messages received");
      report_test(6, "model drained");

      $display("Summary: %0d checks, %0d errors, %0d sent, %0d received",
               check_total, error_count, sent_count, recv_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* system_2x2_noc.f */
+incdir+.
noc_pkg.sv
noc_fifo.sv
noc_router.sv
noc_endpoint.sv
system_2x2_noc.sv
tb_system_2x2_noc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the 2x2 NoC testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f system_2x2_noc.f \
   --top-module tb_system_2x2_noc -o tb_system_2x2_noc
out=$(./obj_dir/tb_system_2x2_noc)
echo "$out"
if echo "$out" | grep -q "Simulation finished: PASS"; then
   exit 0
fi
exit 1
